//--- run_sim.sh
#!/bin/sh
# Build and run the pce_io testbench with Verilator.
# Exits non-zero on a build error, a simulator error or a reported failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pce_io -f sources.f -o tb_pce_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pce_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0

//--- sources.f
+incdir+src
src/pce_io_pkg.sv
src/audio_mixer.sv
src/pad_multiplexer.sv
src/backup_ram.sv
src/backup_sequencer.sv
src/pce_io_top.sv
test/pce_io_assert.sv
test/tb_pce_io.sv

//--- src/audio_mixer.sv
/* Adds PSG, CD audio and ADPCM per side with one register stage. Results are
   clamped to 20 bits signed and truncated to the DAC width, no dithering. */
`timescale 1ns/1ps
`default_nettype none

`include "pce_io_settings.svh"

module audio_mixer (
	input  wire                   clk_sys,
	input  wire                   arst_n,
	input  wire pce_io_pkg::sample_t psg_l,
	input  wire pce_io_pkg::sample_t psg_r,
	input  wire pce_io_pkg::sample_t cdda_l,
	input  wire pce_io_pkg::sample_t cdda_r,
	input  wire pce_io_pkg::adpcm_t  adpcm,
	output pce_io_pkg::dac_t      dac_l,
	output pce_io_pkg::dac_t      dac_r
);
	import pce_io_pkg::*;

	// Clamp limits of the 20-bit result
	localparam sample_t S_MAX = {1'b0, {(`PCE_SAMPLE_W-1){1'b1}}};
	localparam sample_t S_MIN = {1'b1, {(`PCE_SAMPLE_W-1){1'b0}}};

	mix_t adpcm_term;
	mix_t sum_l;
	mix_t sum_r;

	function automatic dac_t saturate(input mix_t s);
		sample_t clamped;
		if (s > mix_t'(S_MAX))
			clamped = S_MAX;
		else if (s < mix_t'(S_MIN))
			clamped = S_MIN;
		else
			clamped = sample_t'(s);
		return clamped[`PCE_SAMPLE_W-1 -: `PCE_DAC_W]; // Keep the top bits
	endfunction

	// ADPCM sits 4 bits below the PSG scale, same term on both sides
	assign adpcm_term = mix_t'(adpcm) <<< 4;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= mix_t'(psg_l) + mix_t'(cdda_l) + adpcm_term;
			sum_r <= mix_t'(psg_r) + mix_t'(cdda_r) + adpcm_term;
		end
	end

	assign dac_l = saturate(sum_l);
	assign dac_r = saturate(sum_r);

endmodule

`default_nettype wire

//--- src/backup_ram.sv
/* 2 KB true dual-port byte RAM, one clock. A read of the address being written
   on the same port returns the old byte. */
`timescale 1ns/1ps
`default_nettype none

`include "pce_io_settings.svh"

module backup_ram (
	input  wire                        clk_sys,
	input  wire pce_io_pkg::brm_addr_t addr_a,
	input  wire pce_io_pkg::byte_t     wdata_a,
	input  wire                        we_a,
	output pce_io_pkg::byte_t          rdata_a,
	input  wire pce_io_pkg::brm_addr_t addr_b,
	input  wire pce_io_pkg::byte_t     wdata_b,
	input  wire                        we_b,
	output pce_io_pkg::byte_t          rdata_b
);
	import pce_io_pkg::*;

	localparam int DEPTH = 1 << `PCE_BRM_AW;

	byte_t mem [DEPTH];

	// Console side
	always @(posedge clk_sys) begin
		if (we_a)
			mem[addr_a] <= wdata_a;
		rdata_a <= mem[addr_a];
	end

	// SD host side
	always @(posedge clk_sys) begin
		if (we_b)
			mem[addr_b] <= wdata_b;
		rdata_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

//--- src/backup_sequencer.sv
/* Load and save of the backup image as four SD sector transfers. Mount and save
   requests that arrive while a transfer runs are dropped. */
`timescale 1ns/1ps
`default_nettype none

`include "pce_io_settings.svh"

module backup_sequencer (
	input  wire                  clk_sys,
	input  wire                  arst_n,
	input  wire                  img_mount,
	input  wire                  img_size_nz,
	input  wire                  bk_save,
	input  wire                  download,
	input  wire                  sd_ack,
	output pce_io_pkg::sector_t  sd_lba,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic                 bk_busy,
	output logic                 bk_ena,
	output logic                 bk_reset
);
	import pce_io_pkg::*;

	localparam sector_t LAST_SECTOR = sector_t'(`PCE_SECTORS - 1);

	logic save_q;
	logic download_q;
	logic ack_q;
	logic loading;      // Direction of the running transfer
	logic start_load;
	logic start_save;

	assign start_load = img_mount & img_size_nz & ~bk_busy;
	assign start_save = bk_ena & bk_save & ~save_q & ~bk_busy;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			save_q     <= 1'b0;
			download_q <= 1'b0;
			ack_q      <= 1'b0;
			loading    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_reset   <= 1'b0;
		end else begin
			save_q     <= bk_save;
			download_q <= download;
			ack_q      <= sd_ack;
			bk_reset   <= 1'b0;

			if (img_mount && img_size_nz)
				bk_ena <= 1'b1;
			if (download && !download_q)
				bk_ena <= 1'b0;    // New cart invalidates the image

			// Host took the request
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (start_load || start_save) begin
				bk_busy <= 1'b1;
				loading <= start_load;
				sd_lba  <= '0;
				sd_rd   <= start_load;
				sd_wr   <= ~start_load;
			end else if (bk_busy && ack_q && !sd_ack) begin
				// Sector done
				if (sd_lba == LAST_SECTOR) begin
					bk_busy  <= 1'b0;
					bk_reset <= loading;  // Console restarts on fresh data
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= loading;
					sd_wr  <= ~loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/pad_multiplexer.sv
/* Multi-tap pad port with nibble readout. The port counter runs past the last
   pad and reads idle lines there until the next clear. */
`timescale 1ns/1ps
`default_nettype none

`include "pce_io_settings.svh"

module pad_multiplexer (
	input  wire                   clk_sys,
	input  wire                   arst_n,
	input  wire pce_io_pkg::pad_t pad_0,
	input  wire pce_io_pkg::pad_t pad_1,
	input  wire pce_io_pkg::pad_t pad_2,
	input  wire pce_io_pkg::pad_t pad_3,
	input  wire pce_io_pkg::pad_t pad_4,
	input  wire                   pad_swap,
	input  wire                   turbotap,
	input  wire                   buttons6,
	input  wire                   pad_sel,
	input  wire                   pad_clr,
	output pce_io_pkg::nibble_t   pad_nibble
);
	import pce_io_pkg::*;

	localparam int PORT_W = $clog2(`PCE_PAD_PORTS);

	logic [PORT_W-1:0] port;
	logic              sel_q;
	logic              clr_q;
	logic              high_bank;   // Six-button extra bank
	pad_t              pad_cur;
	logic [15:0]       pad_word;
	nibble_t           nibble_sel;

	// ============================================================
	// Port selection and active-low mapping
	// ============================================================
	always_comb begin
		case (port)
			0:       pad_cur = pad_swap ? pad_1 : pad_0;
			1:       pad_cur = pad_swap ? pad_0 : pad_1;
			2:       pad_cur = pad_2;
			3:       pad_cur = pad_3;
			4:       pad_cur = pad_4;
			default: pad_cur = '0;
		endcase
	end

	always_comb begin
		if (port < PORT_W'(`PCE_PAD_PORTS)) begin
			// Top nibble reads 0, directions reordered for the pad bus
			pad_word = ~{4'hF, pad_cur[11:8],
				pad_cur[1], pad_cur[2], pad_cur[0], pad_cur[3],
				pad_cur[7:4]};
		end else begin
			pad_word = 16'h0FFF;  // No pad behind this port
		end
	end

	assign nibble_sel = pad_word[{high_bank, pad_sel, 2'b00} +: 4];

	// ============================================================
	// Protocol state
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sel_q      <= 1'b0;
			clr_q      <= 1'b0;
			port       <= '0;
			high_bank  <= 1'b0;
			pad_nibble <= '0;
		end else begin
			sel_q <= pad_sel;
			clr_q <= pad_clr;
			if (pad_clr) begin
				port       <= '0;
				pad_nibble <= '0;
				// Each clear flips banks on six-button pads
				if (!clr_q)
					high_bank <= ~high_bank & buttons6;
			end else begin
				pad_nibble <= nibble_sel;
				if (pad_sel && !sel_q && turbotap)
					port <= port + 1'b1;  // Next tap port
			end
		end
	end

endmodule

`default_nettype wire

//--- src/pce_io_pkg.sv
/* Shared types for the console I/O glue. Audio types are signed two's complement. */
`default_nettype none

`include "pce_io_settings.svh"

package pce_io_pkg;

	// Audio samples
	typedef logic signed [`PCE_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`PCE_ADPCM_W-1:0]  adpcm_t;
	typedef logic signed [`PCE_MIX_W-1:0]    mix_t;
	typedef logic signed [`PCE_DAC_W-1:0]    dac_t;

	// Pad word: 11:8 extra buttons, 7:4 buttons, 3:0 directions
	typedef logic [`PCE_PAD_W-1:0] pad_t;
	typedef logic [3:0]            nibble_t;

	// Backup RAM addressing
	typedef logic [`PCE_BRM_AW-1:0]            brm_addr_t;
	typedef logic [$clog2(`PCE_SECTORS)-1:0]   sector_t;
	typedef logic [`PCE_SECTOR_AW-1:0]         buff_addr_t;
	typedef logic [7:0]                        byte_t;

endpackage

`default_nettype wire

//--- src/pce_io_settings.svh
/* Widths and counts for the console I/O glue. The sector address width and the
   sector count must together cover the backup address width. */
`ifndef PCE_IO_SETTINGS_SVH
`define PCE_IO_SETTINGS_SVH

// Audio path
`define PCE_SAMPLE_W   20  // PSG and CD-audio samples
`define PCE_ADPCM_W    16
`define PCE_MIX_W      22  // Two guard bits over the sample width
`define PCE_DAC_W      16

// Pads
`define PCE_PAD_PORTS  5
`define PCE_PAD_W      12

// Backup RAM, 2 KB as four 512-byte sectors
`define PCE_BRM_AW     11
`define PCE_SECTOR_AW  9
`define PCE_SECTORS    4

`endif

//--- src/pce_io_top.sv
/* Console I/O glue: audio mixer, pad multiplexer and backup RAM with SD loader.
   SD buffer writes only land while the host holds sd_ack. */
`timescale 1ns/1ps
`default_nettype none

`include "pce_io_settings.svh"

module pce_io_top (
	input  wire                         clk_sys,
	input  wire                         arst_n,
	input  wire pce_io_pkg::sample_t    psg_l,
	input  wire pce_io_pkg::sample_t    psg_r,
	input  wire pce_io_pkg::sample_t    cdda_l,
	input  wire pce_io_pkg::sample_t    cdda_r,
	input  wire pce_io_pkg::adpcm_t     adpcm,
	output pce_io_pkg::dac_t            dac_l,
	output pce_io_pkg::dac_t            dac_r,
	input  wire pce_io_pkg::pad_t       pad_0,
	input  wire pce_io_pkg::pad_t       pad_1,
	input  wire pce_io_pkg::pad_t       pad_2,
	input  wire pce_io_pkg::pad_t       pad_3,
	input  wire pce_io_pkg::pad_t       pad_4,
	input  wire                         pad_sel,
	input  wire                         pad_clr,
	input  wire                         turbotap,
	input  wire                         buttons6,
	input  wire                         pad_swap,
	output pce_io_pkg::nibble_t         pad_nibble,
	input  wire pce_io_pkg::brm_addr_t  brm_addr,
	input  wire pce_io_pkg::byte_t      brm_wdata,
	input  wire                         brm_we,
	output pce_io_pkg::byte_t           brm_rdata,
	input  wire                         img_mount,
	input  wire                         img_size_nz,
	input  wire                         bk_save,
	input  wire                         download,
	input  wire                         sd_ack,
	input  wire pce_io_pkg::buff_addr_t sd_buff_addr,
	input  wire pce_io_pkg::byte_t      sd_buff_wdata,
	input  wire                         sd_buff_we,
	output pce_io_pkg::byte_t           sd_buff_rdata,
	output pce_io_pkg::sector_t         sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic                        bk_ena,
	output logic                        bk_busy,
	output logic                        bk_reset
);
	import pce_io_pkg::*;

	brm_addr_t sd_ram_addr;
	logic      sd_ram_we;

	// Sector index picks the 512-byte window
	assign sd_ram_addr = {sd_lba, sd_buff_addr};
	assign sd_ram_we   = sd_buff_we & sd_ack;

	audio_mixer i_mixer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.psg_l   (psg_l),
		.psg_r   (psg_r),
		.cdda_l  (cdda_l),
		.cdda_r  (cdda_r),
		.adpcm   (adpcm),
		.dac_l   (dac_l),
		.dac_r   (dac_r)
	);

	pad_multiplexer i_pads (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.pad_0      (pad_0),
		.pad_1      (pad_1),
		.pad_2      (pad_2),
		.pad_3      (pad_3),
		.pad_4      (pad_4),
		.pad_swap   (pad_swap),
		.turbotap   (turbotap),
		.buttons6   (buttons6),
		.pad_sel    (pad_sel),
		.pad_clr    (pad_clr),
		.pad_nibble (pad_nibble)
	);

	backup_ram i_brm (
		.clk_sys (clk_sys),
		.addr_a  (brm_addr),
		.wdata_a (brm_wdata),
		.we_a    (brm_we),
		.rdata_a (brm_rdata),
		.addr_b  (sd_ram_addr),
		.wdata_b (sd_buff_wdata),
		.we_b    (sd_ram_we),
		.rdata_b (sd_buff_rdata)
	);

	backup_sequencer i_seq (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.img_mount   (img_mount),
		.img_size_nz (img_size_nz),
		.bk_save     (bk_save),
		.download    (download),
		.sd_ack      (sd_ack),
		.sd_lba      (sd_lba),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.bk_busy     (bk_busy),
		.bk_ena      (bk_ena),
		.bk_reset    (bk_reset)
	);

endmodule

`default_nettype wire

//--- test/pce_io_assert.sv
/* Protocol checks bound into pce_io_top. Checks are off while arst_n is low. */
`timescale 1ns/1ps
`default_nettype none

module pce_io_assert (
	input wire                      clk_sys,
	input wire                      arst_n,
	input wire                      sd_rd,
	input wire                      sd_wr,
	input wire                      bk_reset,
	input wire                      pad_clr,
	input wire pce_io_pkg::nibble_t pad_nibble
);
	import pce_io_pkg::*;

	// One SD direction at a time
	a_rd_wr_excl : assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	a_reset_pulse : assert property (@(posedge clk_sys) disable iff (!arst_n)
		bk_reset |=> !bk_reset)
		else $error("bk_reset held longer than one cycle");

	// Clear blanks the pad bus
	a_clr_nibble : assert property (@(posedge clk_sys) disable iff (!arst_n)
		pad_clr |=> (pad_nibble == 4'h0))
		else $error("pad_nibble not zero after pad_clr");

endmodule

bind pce_io_top pce_io_assert i_assert (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.sd_rd      (sd_rd),
	.sd_wr      (sd_wr),
	.bk_reset   (bk_reset),
	.pad_clr    (pad_clr),
	.pad_nibble (pad_nibble)
);

`default_nettype wire

//--- test/tb_pce_io.sv
/* Testbench for pce_io_top with a simple SD host model. Assumes the host answers
   every sector request at once and streams one byte per clock. */
`timescale 1ns/1ps
`default_nettype none

`include "pce_io_settings.svh"

module tb_pce_io;
	import pce_io_pkg::*;

	localparam int IMG_BYTES    = 1 << `PCE_BRM_AW;
	localparam int SECTOR_BYTES = 1 << `PCE_SECTOR_AW;
	localparam int SAT_MAX      = (1 << (`PCE_SAMPLE_W - 1)) - 1;
	localparam int SAT_MIN      = -(1 << (`PCE_SAMPLE_W - 1));
	localparam int REQ_TIMEOUT  = 64;
	localparam int BUSY_TIMEOUT = 64;
	localparam int SAVE_WATCH   = 100;

	typedef struct packed {
		logic [19:0] psg_l;
		logic [19:0] psg_r;
		logic [19:0] cdda_l;
		logic [19:0] cdda_r;
		logic [15:0] adpcm;
		logic [15:0] dac_l;
		logic [15:0] dac_r;
	} audio_row_t;

	typedef struct packed {
		logic [11:0] word;
		logic        sel;
		logic        b6;
		logic [3:0]  nib;
	} pad_row_t;

	logic clk_sys;
	logic arst_n;
	sample_t psg_l, psg_r, cdda_l, cdda_r;
	adpcm_t adpcm;
	dac_t dac_l, dac_r;
	pad_t pad_0, pad_1, pad_2, pad_3, pad_4;
	logic pad_sel, pad_clr, turbotap, buttons6, pad_swap;
	nibble_t pad_nibble;
	brm_addr_t brm_addr;
	byte_t brm_wdata, brm_rdata;
	logic brm_we;
	logic img_mount, img_size_nz, bk_save, download, sd_ack, sd_buff_we;
	buff_addr_t sd_buff_addr;
	byte_t sd_buff_wdata, sd_buff_rdata;
	sector_t sd_lba;
	logic sd_rd, sd_wr, bk_ena, bk_busy, bk_reset;

	int checks;
	int errors;
	int tests_run;
	int tests_failed;
	int reset_pulses;
	logic [31:0] rng;
	byte_t image [IMG_BYTES];
	pad_t walk_words [5];

	// Fixed rows with dac values worked out by hand
	audio_row_t audio_table [6] = '{
		'{20'h00000, 20'h00000, 20'h00000, 20'h00000, 16'h0000, 16'h0000, 16'h0000},
		'{20'h00010, 20'h00020, 20'h00000, 20'h00010, 16'h0001, 16'h0002, 16'h0004},
		'{20'h7FFFF, 20'h40000, 20'h00001, 20'h40000, 16'h0000, 16'h7FFF, 16'h7FFF},
		'{20'h80000, 20'hC0000, 20'hFFFFF, 20'h00000, 16'h8000, 16'h8000, 16'h8000},
		'{20'hFFFF0, 20'h00010, 20'h00000, 20'h00000, 16'h7FFF, 16'h7FFE, 16'h7FFF},
		'{20'h01230, 20'hFFFE0, 20'hFF000, 20'h00000, 16'hFFFF, 16'h0022, 16'hFFFD}
	};

	// Bank state carries over from row to row
	pad_row_t pad_table [8] = '{
		'{12'h0F0, 1'b0, 1'b0, 4'h0},
		'{12'h0A5, 1'b0, 1'b0, 4'h5},
		'{12'h0A5, 1'b1, 1'b0, 4'h9},
		'{12'h009, 1'b1, 1'b0, 4'hC},
		'{12'h6C2, 1'b0, 1'b1, 4'h9},
		'{12'h6C2, 1'b1, 1'b1, 4'h7},
		'{12'h3FF, 1'b1, 1'b1, 4'h0},
		'{12'h31F, 1'b0, 1'b0, 4'hE}
	};

	pce_io_top i_dut (
		.clk_sys (clk_sys), .arst_n (arst_n),
		.psg_l (psg_l), .psg_r (psg_r), .cdda_l (cdda_l), .cdda_r (cdda_r),
		.adpcm (adpcm), .dac_l (dac_l), .dac_r (dac_r),
		.pad_0 (pad_0), .pad_1 (pad_1), .pad_2 (pad_2), .pad_3 (pad_3), .pad_4 (pad_4),
		.pad_sel (pad_sel), .pad_clr (pad_clr), .turbotap (turbotap),
		.buttons6 (buttons6), .pad_swap (pad_swap), .pad_nibble (pad_nibble),
		.brm_addr (brm_addr), .brm_wdata (brm_wdata), .brm_we (brm_we),
		.brm_rdata (brm_rdata),
		.img_mount (img_mount), .img_size_nz (img_size_nz), .bk_save (bk_save),
		.download (download), .sd_ack (sd_ack), .sd_buff_addr (sd_buff_addr),
		.sd_buff_wdata (sd_buff_wdata), .sd_buff_we (sd_buff_we),
		.sd_buff_rdata (sd_buff_rdata), .sd_lba (sd_lba), .sd_rd (sd_rd),
		.sd_wr (sd_wr), .bk_ena (bk_ena), .bk_busy (bk_busy), .bk_reset (bk_reset)
	);

	always #5 clk_sys = ~clk_sys;

	// Counted mid-cycle away from the edge
	always @(negedge clk_sys) begin
		if (arst_n && bk_reset)
			reset_pulses++;
	end

	// ============================================================
	// Helpers
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Sum, clamp to 20 bits, keep the top 16
	function automatic logic [15:0] expect_dac(input logic [19:0] psg,
		input logic [19:0] cdda, input logic [15:0] adp);
		int s;
		s = int'($signed(psg)) + int'($signed(cdda)) + int'($signed(adp)) * 16;
		if (s > SAT_MAX)
			s = SAT_MAX;
		else if (s < SAT_MIN)
			s = SAT_MIN;
		return s[19:4];
	endfunction

	function automatic logic [3:0] expect_nibble(input logic [11:0] p, input bit idle,
		input bit bank, input bit sel);
		logic [3:0] n;
		if (idle)
			n = (bank && sel) ? 4'h0 : 4'hF;   // Port without a pad
		else begin
			case ({bank, sel})
				2'b00:   n = ~p[7:4];
				2'b01:   n = ~{p[1], p[2], p[0], p[3]};
				2'b10:   n = ~p[11:8];
				default: n = 4'h0;
			endcase
		end
		return n;
	endfunction

	function automatic byte_t fill_byte(input int a);
		logic [10:0] x;
		x = a[10:0];
		return x[7:0] ^ {x[10:8], x[10:8], x[9:8]} ^ 8'hA5;
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (expected === actual) else begin
			errors++;
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic finish_test(input string name, input int base);
		tests_run++;
		if (errors == base)
			$display("%s: passed", name);
		else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - base);
		end
	endtask

	task automatic clear_pads();
		pad_sel = 1'b0;
		pad_clr = 1'b1;
		next_cycle();
		pad_clr = 1'b0;
	endtask

	task automatic wait_request(input bit want_read, input int sec, output bit ok);
		int n;
		logic req;
		n = 0;
		req = want_read ? sd_rd : sd_wr;
		while (!req && n < REQ_TIMEOUT) begin
			next_cycle();
			n++;
			req = want_read ? sd_rd : sd_wr;
		end
		checks++;
		assert (req) else begin
			errors++;
			$display("Timeout: no %s request for sector %0d", want_read ? "read" : "write", sec);
		end
		ok = req;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (bk_busy && n < BUSY_TIMEOUT) begin
			next_cycle();
			n++;
		end
		checks++;
		assert (!bk_busy) else begin
			errors++;
			$display("Timeout: bk_busy never dropped after the transfer");
		end
	endtask

	// SD host side of one load sector
	task automatic host_load_sector(input int sec);
		bit ok;
		int i;
		wait_request(1'b1, sec, ok);
		if (!ok)
			return;
		check_value("load_lba", 32'(sec), 32'(sd_lba));
		sd_ack = 1'b1;
		next_cycle();
		check_value("load_rd_drop", 0, 32'(sd_rd));
		for (i = 0; i < SECTOR_BYTES; i++) begin
			sd_buff_addr  = buff_addr_t'(i);
			sd_buff_wdata = image[sec * SECTOR_BYTES + i];
			sd_buff_we    = 1'b1;
			next_cycle();
		end
		sd_buff_we = 1'b0;
		sd_ack     = 1'b0;
		next_cycle();
	endtask

	task automatic host_save_sector(input int sec);
		bit ok;
		int i;
		wait_request(1'b0, sec, ok);
		if (!ok)
			return;
		check_value("save_lba", 32'(sec), 32'(sd_lba));
		sd_ack = 1'b1;
		next_cycle();
		for (i = 0; i < SECTOR_BYTES; i++) begin
			sd_buff_addr = buff_addr_t'(i);
			next_cycle();   // Data one cycle after the address
			check_value("save_data", 32'(fill_byte(sec * SECTOR_BYTES + i)),
				32'(sd_buff_rdata));
		end
		sd_ack = 1'b0;
		next_cycle();
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic run_audio_test();
		int base;
		int i;
		audio_row_t r;
		base = errors;
		for (i = 0; i < 18; i++) begin
			if (i < 6)
				r = audio_table[i];
			else begin
				rng = xorshift32(rng);
				r.psg_l = rng[19:0];
				r.adpcm = rng[31:16];
				rng = xorshift32(rng);
				r.psg_r = rng[19:0];
				rng = xorshift32(rng);
				r.cdda_l = rng[19:0];
				rng = xorshift32(rng);
				r.cdda_r = rng[19:0];
				r.dac_l = expect_dac(r.psg_l, r.cdda_l, r.adpcm);
				r.dac_r = expect_dac(r.psg_r, r.cdda_r, r.adpcm);
			end
			psg_l  = r.psg_l;
			psg_r  = r.psg_r;
			cdda_l = r.cdda_l;
			cdda_r = r.cdda_r;
			adpcm  = r.adpcm;
			next_cycle();
			check_value($sformatf("audio row %0d left", i), {16'h0, r.dac_l}, {16'h0, dac_l});
			check_value($sformatf("audio row %0d right", i), {16'h0, r.dac_r}, {16'h0, dac_r});
		end
		finish_test("audio_table", base);
	endtask

	task automatic run_pad_map_test();
		int base;
		int i;
		base = errors;
		for (i = 0; i < 8; i++) begin
			pad_0    = pad_table[i].word;
			buttons6 = pad_table[i].b6;
			clear_pads();
			pad_sel = pad_table[i].sel;
			next_cycle();
			check_value($sformatf("pad_map row %0d", i), 32'(pad_table[i].nib),
				32'(pad_nibble));
		end
		buttons6 = 1'b0;
		finish_test("pad_map", base);
	endtask

	task automatic walk_ports(input bit swap, input bit tap);
		int k;
		int idx;
		logic [11:0] w;
		pad_swap = swap;
		turbotap = tap;
		clear_pads();
		for (k = 0; k < 6; k++) begin
			idx = tap ? k : 0;
			if (swap && idx < 2)
				idx = 1 - idx;
			w = (idx < 5) ? walk_words[idx] : 12'h000;
			pad_sel = 1'b0;
			next_cycle();
			check_value($sformatf("turbo port %0d buttons", k),
				32'(expect_nibble(w, idx >= 5, 1'b0, 1'b0)), 32'(pad_nibble));
			pad_sel = 1'b1;  // Rising edge steps the tap
			next_cycle();
			check_value($sformatf("turbo port %0d directions", k),
				32'(expect_nibble(w, idx >= 5, 1'b0, 1'b1)), 32'(pad_nibble));
		end
		pad_sel = 1'b0;
	endtask

	task automatic run_turbo_test();
		int base;
		base = errors;
		walk_words[0] = 12'h1E4;
		walk_words[1] = 12'h2D8;
		walk_words[2] = 12'h4B1;
		walk_words[3] = 12'h872;
		walk_words[4] = 12'hF0C;
		pad_0 = walk_words[0];
		pad_1 = walk_words[1];
		pad_2 = walk_words[2];
		pad_3 = walk_words[3];
		pad_4 = walk_words[4];
		walk_ports(1'b0, 1'b1);
		walk_ports(1'b1, 1'b1);
		walk_ports(1'b0, 1'b0);
		turbotap = 1'b0;
		finish_test("turbo_walk", base);
	endtask

	task automatic run_load_test();
		int base;
		int k;
		int pulses_before;
		base = errors;
		for (k = 0; k < IMG_BYTES; k++) begin
			rng = xorshift32(rng);
			image[k] = rng[7:0];
		end
		pulses_before = reset_pulses;
		img_size_nz = 1'b1;
		img_mount   = 1'b1;
		next_cycle();
		img_mount = 1'b0;
		check_value("load_ena", 1, 32'(bk_ena));
		check_value("load_busy", 1, 32'(bk_busy));
		for (k = 0; k < `PCE_SECTORS; k++)
			host_load_sector(k);
		wait_idle();
		next_cycle();
		next_cycle();
		check_value("load_reset_pulses", 1, reset_pulses - pulses_before);
		for (k = 0; k < IMG_BYTES; k++) begin
			brm_addr = brm_addr_t'(k);
			next_cycle();
			check_value("load_readback", 32'(image[k]), 32'(brm_rdata));
		end
		finish_test("backup_load", base);
	endtask

	task automatic run_save_test();
		int base;
		int k;
		bit seen;
		base = errors;
		brm_we = 1'b1;
		for (k = 0; k < IMG_BYTES; k++) begin
			brm_addr  = brm_addr_t'(k);
			brm_wdata = fill_byte(k);
			next_cycle();
		end
		brm_we  = 1'b0;
		bk_save = 1'b1;
		next_cycle();
		check_value("save_busy", 1, 32'(bk_busy));
		for (k = 0; k < `PCE_SECTORS; k++)
			host_save_sector(k);
		wait_idle();
		bk_save = 1'b0;
		// New cart download disables the backup
		download = 1'b1;
		next_cycle();
		download = 1'b0;
		next_cycle();
		check_value("save_ena_cleared", 0, 32'(bk_ena));
		bk_save = 1'b1;
		seen = 1'b0;
		for (k = 0; k < SAVE_WATCH; k++) begin
			next_cycle();
			if (sd_wr)
				seen = 1'b1;
		end
		bk_save = 1'b0;
		checks++;
		assert (!seen) else begin
			errors++;
			$display("Save request raised sd_wr although the backup was disabled");
		end
		finish_test("backup_save", base);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		clk_sys = 1'b0;
		arst_n = 1'b0;
		psg_l = '0;
		psg_r = '0;
		cdda_l = '0;
		cdda_r = '0;
		adpcm = '0;
		pad_0 = '0;
		pad_1 = '0;
		pad_2 = '0;
		pad_3 = '0;
		pad_4 = '0;
		pad_sel = 1'b0;
		pad_clr = 1'b0;
		turbotap = 1'b0;
		buttons6 = 1'b0;
		pad_swap = 1'b0;
		brm_addr = '0;
		brm_wdata = '0;
		brm_we = 1'b0;
		img_mount = 1'b0;
		img_size_nz = 1'b0;
		bk_save = 1'b0;
		download = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wdata = '0;
		sd_buff_we = 1'b0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reset_pulses = 0;
		rng = 32'h8db8de5f;

		repeat (5) @(posedge clk_sys);
		#1 arst_n = 1'b1;

		check_value("reset_outputs", 0,
			32'({sd_rd, sd_wr, bk_busy, bk_ena, bk_reset, pad_nibble}));
		run_audio_test();
		run_pad_map_test();
		run_turbo_test();
		run_load_test();
		run_save_test();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
